//--- logic/pa_pkg.sv
// arithmetic unit shared types
`default_nettype none

package pa_pkg;

	localparam int PA_W = 16;
	// 181-style slices across the word
	localparam int PA_NSLICE = 4;

	// bit 0 is the most significant bit
	typedef logic [0:PA_W-1] pa_word_t;

	typedef enum logic [3:0] {
		OP_NOP      = 4'd0,
		OP_LD_AC    = 4'd1,
		OP_LD_AR    = 4'd2,
		OP_LD_IC    = 4'd3,
		OP_AR_INC   = 4'd4,
		OP_AR_SUB4  = 4'd5,
		OP_IC_INC   = 4'd6,
		OP_ALU      = 4'd7,
		OP_AT_SHIFT = 4'd8
	} pa_op_e;

	typedef enum logic [2:0] {
		FN_ADD    = 3'd0,
		FN_SUB    = 3'd1,
		FN_AND    = 3'd2,
		FN_OR     = 3'd3,
		FN_XOR    = 3'd4,
		FN_PASS_A = 3'd5
	} pa_alu_fn_e;

	// W bus sources, same order as the select lines
	typedef enum logic [2:0] {
		W_IR         = 3'd0,
		W_KL         = 3'd1,
		W_RDT        = 3'd2,
		W_ZERO_HI_AC = 3'd3,
		W_KI         = 3'd4,
		W_AT         = 3'd5,
		W_AC         = 3'd6,
		W_A          = 3'd7
	} pa_wsel_e;

	typedef enum logic [1:0] {
		A_L_IR = 2'd0,
		A_IC   = 2'd1,
		A_AR   = 2'd2,
		A_L    = 2'd3
	} pa_asel_e;

	typedef enum logic [1:0] {
		AD_NONE = 2'd0,
		AD_AR   = 2'd1,
		AD_IC   = 2'd2
	} pa_adsel_e;

	typedef struct packed {
		pa_op_e     op;
		pa_alu_fn_e alu_fn;
		pa_wsel_e   wsel;
		pa_asel_e   asel;
		logic       blank_w_hi;
		logic       blank_w_lo;
		logic       blank_a_hi;
		logic       blank_a_mid;
		logic       blank_a_lo;
		logic       carry_in;
		logic       drive_dt;
		pa_adsel_e  adsel;
		logic       at_fill;
	} pa_cmd_t;

	typedef struct packed {
		pa_word_t ir;
		pa_word_t kl;
		pa_word_t ki;
		pa_word_t rdt;
		pa_word_t l;
	} pa_data_t;

	typedef struct packed {
		pa_word_t ac;
		pa_word_t ar;
		pa_word_t ic;
		pa_word_t at;
	} pa_regs_t;

	typedef struct packed {
		logic carry;
		logic zero;
		logic sign;
		logic equal;
	} pa_flags_t;

	typedef struct packed {
		pa_wsel_e wsel;
		pa_asel_e asel;
		logic     blank_w_hi;
		logic     blank_w_lo;
		logic     blank_a_hi;
		logic     blank_a_mid;
		logic     blank_a_lo;
	} pa_busctl_t;

	// s is S3..S0 of the 181, m high selects logic mode
	typedef struct packed {
		logic [3:0] s;
		logic       m;
		logic       cn_n;
	} pa_aluctl_t;

	typedef struct packed {
		logic ac_we;
		logic ar_we;
		logic ic_we;
		logic ar_inc;
		logic ar_sub4;
		logic ic_inc;
		logic at_load;
		logic at_shift;
		logic flags_we;
		logic at_fill;
	} pa_regctl_t;

endpackage

`default_nettype wire

//--- logic/pa_control.sv
// command decoder
`timescale 1ns/10ps
`default_nettype none

module pa_control import pa_pkg::*; (
	input  pa_cmd_t    cmd,
	input  logic       op_valid,
	output pa_busctl_t busctl,
	output pa_aluctl_t aluctl,
	output pa_regctl_t regctl
);

	// bus selects go straight through
	always_comb begin
		busctl.wsel        = cmd.wsel;
		busctl.asel        = cmd.asel;
		busctl.blank_w_hi  = cmd.blank_w_hi;
		busctl.blank_w_lo  = cmd.blank_w_lo;
		busctl.blank_a_hi  = cmd.blank_a_hi;
		busctl.blank_a_mid = cmd.blank_a_mid;
		busctl.blank_a_lo  = cmd.blank_a_lo;
	end

	// 181 function select, active-high data
	always_comb begin
		aluctl.cn_n = ~cmd.carry_in;
		case (cmd.alu_fn)
			FN_ADD: begin
				aluctl.s = 4'b1001;
				aluctl.m = 1'b0;
			end
			FN_SUB: begin
				aluctl.s = 4'b0110;
				aluctl.m = 1'b0;
			end
			FN_AND: begin
				aluctl.s = 4'b1011;
				aluctl.m = 1'b1;
			end
			FN_OR: begin
				aluctl.s = 4'b1110;
				aluctl.m = 1'b1;
			end
			FN_XOR: begin
				aluctl.s = 4'b0110;
				aluctl.m = 1'b1;
			end
			default: begin
				// pass a
				aluctl.s = 4'b1111;
				aluctl.m = 1'b1;
			end
		endcase
	end

	// write enables, only for a valid command
	always_comb begin
		regctl = '0;
		regctl.at_fill = cmd.at_fill;
		if (op_valid) begin
			case (cmd.op)
				OP_LD_AC:   regctl.ac_we = 1'b1;
				OP_LD_AR:   regctl.ar_we = 1'b1;
				OP_LD_IC:   regctl.ic_we = 1'b1;
				OP_AR_INC:  regctl.ar_inc = 1'b1;
				OP_AR_SUB4: regctl.ar_sub4 = 1'b1;
				OP_IC_INC:  regctl.ic_inc = 1'b1;
				OP_ALU: begin
					regctl.at_load  = 1'b1;
					regctl.flags_we = 1'b1;
				end
				OP_AT_SHIFT: regctl.at_shift = 1'b1;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/pa_bus_mux.sv
// W and A bus selection
`timescale 1ns/10ps
`default_nettype none

module pa_bus_mux import pa_pkg::*; (
	input  pa_busctl_t busctl,
	input  pa_data_t   data,
	input  pa_regs_t   regs,
	output pa_word_t   w_bus,
	output pa_word_t   a_bus
);

	pa_word_t a_src;
	logic [0:7] w_hi;
	logic [0:7] w_lo;

	// A bus source word
	always_comb begin
		case (busctl.asel)
			// odd split: low byte of l on top, ir below
			A_L_IR:  a_src = {data.l[8:15], data.ir[8:15]};
			A_IC:    a_src = regs.ic;
			A_AR:    a_src = regs.ar;
			default: a_src = data.l;
		endcase
	end

	// three fields blanked on their own
	always_comb begin
		a_bus[0:7]   = busctl.blank_a_hi  ? 8'd0 : a_src[0:7];
		a_bus[8:9]   = busctl.blank_a_mid ? 2'd0 : a_src[8:9];
		a_bus[10:15] = busctl.blank_a_lo  ? 6'd0 : a_src[10:15];
	end

	// W bus, one byte pair per source
	always_comb begin
		case (busctl.wsel)
			W_IR: begin
				w_hi = data.ir[0:7];
				w_lo = data.ir[8:15];
			end
			W_KL: begin
				w_hi = data.kl[0:7];
				w_lo = data.kl[8:15];
			end
			W_RDT: begin
				w_hi = data.rdt[0:7];
				w_lo = data.rdt[8:15];
			end
			W_ZERO_HI_AC: begin
				// high byte of ac moves down
				w_hi = 8'd0;
				w_lo = regs.ac[0:7];
			end
			W_KI: begin
				w_hi = data.ki[0:7];
				w_lo = data.ki[8:15];
			end
			W_AT: begin
				w_hi = regs.at[0:7];
				w_lo = regs.at[8:15];
			end
			W_AC: begin
				w_hi = regs.ac[0:7];
				w_lo = regs.ac[8:15];
			end
			default: begin
				w_hi = a_bus[0:7];
				w_lo = a_bus[8:15];
			end
		endcase
	end

	assign w_bus[0:7]  = busctl.blank_w_hi ? 8'd0 : w_hi;
	assign w_bus[8:15] = busctl.blank_w_lo ? 8'd0 : w_lo;

endmodule

`default_nettype wire

//--- logic/pa_alu.sv
// 181-style function unit with lookahead carry
`timescale 1ns/10ps
`default_nettype none

module pa_alu import pa_pkg::*; (
	input  pa_aluctl_t aluctl,
	input  pa_word_t   a_bus,
	input  pa_word_t   ac,
	output pa_word_t   result,
	output pa_flags_t  next_flags
);

	// carries into each of four positions, position 3 is the lowest
	function automatic logic [0:3] carries4(input logic [0:3] g, input logic [0:3] p,
			input logic cin);
		logic [0:3] c;
		c[3] = cin;
		c[2] = g[3] | (p[3] & cin);
		c[1] = g[2] | (p[2] & g[3]) | (p[2] & p[3] & cin);
		c[0] = g[1] | (p[1] & g[2]) | (p[1] & p[2] & g[3]) | (p[1] & p[2] & p[3] & cin);
		return c;
	endfunction

	function automatic logic group_g(input logic [0:3] g, input logic [0:3] p);
		return g[0] | (p[0] & g[1]) | (p[0] & p[1] & g[2]) | (p[0] & p[1] & p[2] & g[3]);
	endfunction

	pa_word_t e_n, d_n;
	pa_word_t g_bit, p_bit, h_bit;
	logic [0:PA_NSLICE-1] sl_g, sl_p, sl_eq, sl_zero, sl_cin;
	logic cin, cout;

	// per-bit terms shared by all slices
	assign e_n = ~((a_bus & ac & {PA_W{aluctl.s[3]}}) | (a_bus & ~ac & {PA_W{aluctl.s[2]}}));
	assign d_n = ~(a_bus | (ac & {PA_W{aluctl.s[0]}}) | (~ac & {PA_W{aluctl.s[1]}}));
	assign g_bit = ~e_n;
	assign p_bit = ~d_n;
	assign h_bit = e_n ^ d_n;

	assign cin = ~aluctl.cn_n;

	genvar k;
	generate
		for (k = 0; k < PA_NSLICE; k++) begin : g_slice
			logic [0:3] c_in_bit;

			assign sl_g[k] = group_g(g_bit[4*k +: 4], p_bit[4*k +: 4]);
			assign sl_p[k] = &p_bit[4*k +: 4];
			assign sl_eq[k] = &(a_bus[4*k +: 4] ~^ ac[4*k +: 4]);
			assign c_in_bit = carries4(g_bit[4*k +: 4], p_bit[4*k +: 4], sl_cin[k]);
			// logic mode holds the carry term high
			assign result[4*k +: 4] = h_bit[4*k +: 4] ^ (c_in_bit | {4{aluctl.m}});
			assign sl_zero[k] = ~|result[4*k +: 4];
		end
	endgenerate

	// 182 lookahead across the slices
	assign sl_cin = carries4(sl_g, sl_p, cin);
	assign cout = sl_g[0] | (sl_p[0] & sl_cin[0]);

	always_comb begin
		next_flags.carry = cout & ~aluctl.m;
		next_flags.zero  = &sl_zero;
		next_flags.sign  = result[0];
		next_flags.equal = &sl_eq;
	end

endmodule

`default_nettype wire

//--- logic/pa_registers.sv
// ac, ar, ic, at and flags
`timescale 1ns/10ps
`default_nettype none

module pa_registers import pa_pkg::*; (
	input  logic       __ic_cu,
	input  logic       __ic_load,
	input  pa_regctl_t regctl,
	input  pa_word_t   w_bus,
	input  pa_word_t   alu_result,
	input  pa_flags_t  next_flags,
	output pa_regs_t   regs,
	output pa_flags_t  flags
);

	pa_word_t ac, ar, ic, at;
	pa_flags_t flag_q;

	// accumulator
	always_ff @(posedge __ic_cu or posedge __ic_load) begin
		if (__ic_load) begin
			ac <= '0;
		end else if (regctl.ac_we) begin
			ac <= w_bus;
		end
	end

	// address register, wraps both ways
	always_ff @(posedge __ic_cu or posedge __ic_load) begin
		if (__ic_load) begin
			ar <= '0;
		end else if (regctl.ar_we) begin
			ar <= w_bus;
		end else if (regctl.ar_sub4) begin
			ar <= ar - 16'd4;
		end else if (regctl.ar_inc) begin
			ar <= ar + 16'd1;
		end
	end

	// instruction counter
	always_ff @(posedge __ic_cu or posedge __ic_load) begin
		if (__ic_load) begin
			ic <= '0;
		end else if (regctl.ic_we) begin
			ic <= w_bus;
		end else if (regctl.ic_inc) begin
			ic <= ic + 16'd1;
		end
	end

	// at takes the alu result or shifts toward bit 15
	always_ff @(posedge __ic_cu or posedge __ic_load) begin
		if (__ic_load) begin
			at <= '0;
		end else if (regctl.at_load) begin
			at <= alu_result;
		end else if (regctl.at_shift) begin
			at <= {regctl.at_fill, at[0:PA_W-2]};
		end
	end

	always_ff @(posedge __ic_cu or posedge __ic_load) begin
		if (__ic_load) begin
			flag_q <= '0;
		end else if (regctl.flags_we) begin
			flag_q <= next_flags;
		end
	end

	assign regs.ac = ac;
	assign regs.ar = ar;
	assign regs.ic = ic;
	assign regs.at = at;
	assign flags   = flag_q;

endmodule

`default_nettype wire

//--- logic/pa_top.sv
// arithmetic unit top level
`timescale 1ns/10ps
`default_nettype none

module pa_top import pa_pkg::*; (
	input  logic      __ic_cu,
	input  logic      __ic_load,
	input  logic      op_valid,
	input  pa_cmd_t   cmd,
	input  pa_data_t  data,
	input  logic      barnb,
	output pa_word_t  ddt,
	output pa_word_t  dad,
	output pa_regs_t  regs,
	output pa_flags_t flags,
	output logic      addr_match
);

	pa_busctl_t busctl;
	pa_aluctl_t aluctl;
	pa_regctl_t regctl;
	pa_word_t   w_bus, a_bus, alu_result;
	pa_flags_t  next_flags;

	pa_control u_control (
		.cmd(cmd), .op_valid(op_valid),
		.busctl(busctl), .aluctl(aluctl), .regctl(regctl)
	);

	pa_bus_mux u_bus_mux (
		.busctl(busctl), .data(data), .regs(regs),
		.w_bus(w_bus), .a_bus(a_bus)
	);

	pa_alu u_alu (
		.aluctl(aluctl), .a_bus(a_bus), .ac(regs.ac),
		.result(alu_result), .next_flags(next_flags)
	);

	pa_registers u_registers (
		.__ic_cu(__ic_cu), .__ic_load(__ic_load), .regctl(regctl),
		.w_bus(w_bus), .alu_result(alu_result), .next_flags(next_flags),
		.regs(regs), .flags(flags)
	);

	assign ddt = cmd.drive_dt ? w_bus : '0;

	always_comb begin
		case (cmd.adsel)
			AD_AR:   dad = regs.ar;
			AD_IC:   dad = regs.ic;
			default: dad = '0;
		endcase
	end

	// bit 0 of kl is compared against barnb, not the address
	assign addr_match = (data.kl[0] == barnb) && (data.kl[1:15] == dad[1:15]);

endmodule

`default_nettype wire

//--- verif/pa_tb.sv
// arithmetic unit testbench
`timescale 1ns/10ps
`default_nettype none

module pa_tb import pa_pkg::*; ();

	localparam int N_LINES = 35;
	localparam int N_COLS = 24;
	localparam int RESET_CYCLES = 8;
	localparam int CYCLE_LIMIT = N_LINES + RESET_CYCLES + 20;

	logic __ic_cu, __ic_load, op_valid, barnb, addr_match;
	pa_cmd_t cmd;
	pa_data_t data;
	pa_word_t ddt, dad;
	pa_regs_t regs;
	pa_flags_t flags;

	logic [31:0] stim [0:N_LINES*N_COLS-1];
	int err_dut, err_file;
	int cycles = 0;
	pa_regs_t m_regs;
	pa_flags_t m_flags;

	pa_top u_pa_top (
		.__ic_cu(__ic_cu), .__ic_load(__ic_load), .op_valid(op_valid), .cmd(cmd),
		.data(data), .barnb(barnb), .ddt(ddt), .dad(dad), .regs(regs),
		.flags(flags), .addr_match(addr_match)
	);

	initial begin
		__ic_cu = 1'b0;
		forever #4 __ic_cu = ~__ic_cu;
	end

	always @(posedge __ic_cu) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("sim failed");
			$finish;
		end
	end

	task automatic note_error(input bit from_file);
		if (from_file) err_file++;
		else err_dut++;
	endtask

	task automatic check_word(input string name, input pa_word_t exp, input pa_word_t act,
			input bit from_file);
		if (exp !== act) begin
			$display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
			note_error(from_file);
		end
	endtask

	task automatic check_regs(input string name, input pa_regs_t exp, input pa_regs_t act,
			input bit from_file);
		check_word({name, ".ac"}, exp.ac, act.ac, from_file);
		check_word({name, ".ar"}, exp.ar, act.ar, from_file);
		check_word({name, ".ic"}, exp.ic, act.ic, from_file);
		check_word({name, ".at"}, exp.at, act.at, from_file);
	endtask

	task automatic check_flags(input string name, input pa_flags_t exp, input pa_flags_t act,
			input bit from_file);
		if (exp !== act) begin
			$display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
			note_error(from_file);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act,
			input bit from_file);
		if (exp !== act) begin
			$display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
			note_error(from_file);
		end
	endtask

	// reference model, conventional [15:0] numbering
	function automatic logic [15:0] model_a(input pa_cmd_t c, input pa_data_t d,
			input pa_regs_t r);
		logic [15:0] src, l, ir;
		l = d.l;
		ir = d.ir;
		case (c.asel)
			A_L_IR:  src = {l[7:0], ir[7:0]};
			A_IC:    src = r.ic;
			A_AR:    src = r.ar;
			default: src = l;
		endcase
		return src & {c.blank_a_hi ? 8'h00 : 8'hff, c.blank_a_mid ? 2'b00 : 2'b11,
			c.blank_a_lo ? 6'h00 : 6'h3f};
	endfunction

	function automatic logic [15:0] model_w(input pa_cmd_t c, input pa_data_t d,
			input pa_regs_t r);
		logic [15:0] src, ac;
		ac = r.ac;
		case (c.wsel)
			W_IR:         src = d.ir;
			W_KL:         src = d.kl;
			W_RDT:        src = d.rdt;
			W_ZERO_HI_AC: src = {8'h00, ac[15:8]};
			W_KI:         src = d.ki;
			W_AT:         src = r.at;
			W_AC:         src = ac;
			default:      src = model_a(c, d, r);
		endcase
		return src & {c.blank_w_hi ? 8'h00 : 8'hff, c.blank_w_lo ? 8'h00 : 8'hff};
	endfunction

	task automatic model_step(input pa_cmd_t c, input pa_data_t d, input logic ov);
		logic [15:0] a, ac, res;
		logic [16:0] sum;
		a = model_a(c, d, m_regs);
		ac = m_regs.ac;
		sum = {1'b0, a} + {1'b0, ac} + {16'd0, c.carry_in};
		if (c.alu_fn == FN_SUB) sum = {1'b0, a} + {1'b0, ~ac} + {16'd0, c.carry_in};
		case (c.alu_fn)
			FN_AND:    res = a & ac;
			FN_OR:     res = a | ac;
			FN_XOR:    res = a ^ ac;
			FN_PASS_A: res = a;
			default:   res = sum[15:0];
		endcase
		if (ov) begin
			case (c.op)
				OP_LD_AC:   m_regs.ac = model_w(c, d, m_regs);
				OP_LD_AR:   m_regs.ar = model_w(c, d, m_regs);
				OP_LD_IC:   m_regs.ic = model_w(c, d, m_regs);
				OP_AR_INC:  m_regs.ar = m_regs.ar + 16'd1;
				OP_AR_SUB4: m_regs.ar = m_regs.ar - 16'd4;
				OP_IC_INC:  m_regs.ic = m_regs.ic + 16'd1;
				OP_ALU: begin
					m_regs.at = res;
					m_flags.carry = (c.alu_fn == FN_ADD || c.alu_fn == FN_SUB) ? sum[16] : 1'b0;
					m_flags.zero = (res == 16'h0000);
					m_flags.sign = res[15];
					m_flags.equal = (a == ac);
				end
				// value shift toward the lsb, fill lands in the msb
				OP_AT_SHIFT: m_regs.at = (m_regs.at >> 1) | {c.at_fill, 15'd0};
				default: ;
			endcase
		end
	endtask

	initial begin
		pa_cmd_t lc;
		pa_data_t ld;
		logic lov, lbb, m_match;
		pa_word_t m_ddt, m_dad;
		pa_regs_t f_regs, prev_regs;
		pa_flags_t f_flags, prev_flags;
		int b;
		err_dut = 0;
		err_file = 0;
		cmd <= '0;
		data <= '0;
		op_valid <= 1'b0;
		barnb <= 1'b1;
		m_regs = '0;
		m_flags = '0;
		prev_regs = '0;
		prev_flags = '0;
		$readmemh("verif/pa_stim.txt", stim);
		__ic_load <= 1'b1;
		repeat (RESET_CYCLES) @(posedge __ic_cu);
		__ic_load <= 1'b0;
		@(negedge __ic_cu);
		check_regs("regs", '0, regs, 1'b0);
		check_flags("flags", '0, flags, 1'b0);
		check_word("dad", '0, dad, 1'b0);
		check_bit("addr_match", 1'b0, addr_match, 1'b0);
		for (int i = 0; i < N_LINES; i++) begin
			@(posedge __ic_cu);
			b = i * N_COLS;
			lc.op = pa_op_e'(stim[b][3:0]);
			lc.alu_fn = pa_alu_fn_e'(stim[b+1][2:0]);
			lc.wsel = pa_wsel_e'(stim[b+2][2:0]);
			lc.asel = pa_asel_e'(stim[b+3][1:0]);
			{lc.blank_w_hi, lc.blank_w_lo, lc.blank_a_hi, lc.blank_a_mid,
				lc.blank_a_lo} = stim[b+4][4:0];
			lc.carry_in = stim[b+5][0];
			lc.drive_dt = stim[b+6][0];
			lc.adsel = pa_adsel_e'(stim[b+7][1:0]);
			lc.at_fill = stim[b+8][0];
			lov = stim[b+9][0];
			lbb = stim[b+10][0];
			ld = {stim[b+11][15:0], stim[b+12][15:0], stim[b+13][15:0], stim[b+14][15:0],
				stim[b+15][15:0]};
			f_regs = {stim[b+16][15:0], stim[b+17][15:0], stim[b+18][15:0], stim[b+19][15:0]};
			f_flags = stim[b+20][3:0];
			cmd <= lc;
			data <= ld;
			op_valid <= lov;
			barnb <= lbb;
			// outputs before the edge, then the state after it
			m_ddt = lc.drive_dt ? model_w(lc, ld, m_regs) : '0;
			m_dad = (lc.adsel == AD_AR) ? m_regs.ar : (lc.adsel == AD_IC) ? m_regs.ic : '0;
			// msb against barnb, the other 15 bits against the address
			m_match = (ld.kl[0] == lbb) && (((ld.kl ^ m_dad) & 16'h7fff) == 16'h0000);
			model_step(lc, ld, lov);
			check_word("stim ddt", stim[b+21][15:0], m_ddt, 1'b1);
			check_word("stim dad", stim[b+22][15:0], m_dad, 1'b1);
			check_bit("stim addr_match", stim[b+23][0], m_match, 1'b1);
			check_regs("stim regs", f_regs, m_regs, 1'b1);
			check_flags("stim flags", f_flags, m_flags, 1'b1);
			@(negedge __ic_cu);
			check_word("ddt", stim[b+21][15:0], ddt, 1'b0);
			check_word("dad", stim[b+22][15:0], dad, 1'b0);
			check_bit("addr_match", stim[b+23][0], addr_match, 1'b0);
			check_regs("regs", prev_regs, regs, 1'b0);
			check_flags("flags", prev_flags, flags, 1'b0);
			prev_regs = f_regs;
			prev_flags = f_flags;
		end
		@(posedge __ic_cu);
		op_valid <= 1'b0;
		@(negedge __ic_cu);
		check_regs("regs", prev_regs, regs, 1'b0);
		check_flags("flags", prev_flags, flags, 1'b0);
		$display("errors: dut %0d, stim file %0d", err_dut, err_file);
		if (err_dut == 0 && err_file == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
logic/pa_pkg.sv
logic/pa_control.sv
logic/pa_bus_mux.sv
logic/pa_alu.sv
logic/pa_registers.sv
logic/pa_top.sv
verif/pa_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the arithmetic unit testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -rf "$OBJ" "$LOG"

verilator --binary --timing --timescale 1ns/10ps \
	--top-module pa_tb -f flist.f --Mdir "$OBJ" -o Vpa_tb
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

"./$OBJ/Vpa_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "sim failed" "$LOG"; then
	echo "FAIL"
	exit 1
fi

if ! grep -q "sim passed" "$LOG"; then
	echo "no result line in $LOG"
	exit 1
fi

echo "PASS"
exit 0

//--- verif/pa_stim.txt
// op fn ws as blk(whi wlo ahi amid alo) cin dt ad fill valid barnb ir kl ki rdt l
// then state after the command: ac ar ic at flags(c z s e), outputs before it: ddt dad match
1 0 0 0 00 0 1 0 0 0 1 1234 0000 00FF ABCD 5678 0000 0000 0000 0000 0 1234 0000 0
1 0 0 0 00 0 0 0 0 1 1 1234 0000 00FF ABCD 5678 1234 0000 0000 0000 0 0000 0000 0
2 0 1 0 00 0 1 0 0 1 1 1234 F00F 00FF ABCD 5678 1234 F00F 0000 0000 0 F00F 0000 0
3 0 2 0 00 0 1 0 0 1 1 1234 0000 00FF ABCD 5678 1234 F00F ABCD 0000 0 ABCD 0000 0
1 0 3 0 00 0 1 0 0 1 1 1234 0000 00FF ABCD 5678 0012 F00F ABCD 0000 0 0012 0000 0
2 0 4 0 08 0 1 0 0 1 1 1234 0000 5AFF ABCD 5678 0012 5A00 ABCD 0000 0 5A00 0000 0
3 0 6 0 10 0 0 0 0 1 1 1234 0000 00FF ABCD 5678 0012 5A00 0012 0000 0 0000 0000 0
1 0 7 3 00 0 1 0 0 1 1 1234 0000 00FF ABCD 5678 5678 5A00 0012 0000 0 5678 0000 0
2 0 4 0 00 0 0 1 0 1 1 1234 0000 FFFF ABCD 5678 5678 FFFF 0012 0000 0 0000 5A00 0
4 0 0 0 00 0 0 1 0 1 1 1234 FFFF 00FF ABCD 5678 5678 0000 0012 0000 0 0000 FFFF 1
5 0 0 0 00 0 0 1 0 1 0 1234 0001 00FF ABCD 5678 5678 FFFC 0012 0000 0 0000 0000 0
4 0 0 0 00 0 0 2 0 1 0 1234 0012 00FF ABCD 5678 5678 FFFD 0012 0000 0 0000 0012 1
3 0 4 0 00 0 0 2 0 1 1 1234 0012 FFFF ABCD 5678 5678 FFFD FFFF 0000 0 0000 0012 0
6 0 0 0 00 0 0 2 0 1 1 1234 0000 00FF ABCD 5678 5678 FFFD 0000 0000 0 0000 FFFF 0
5 0 0 0 00 0 0 1 0 1 1 1234 0000 00FF ABCD 5678 5678 FFF9 0000 0000 0 0000 FFFD 0
2 0 4 0 00 0 0 0 0 1 1 1234 0000 0002 ABCD 5678 5678 0002 0000 0000 0 0000 0000 0
5 0 0 0 00 0 0 1 0 1 0 1234 0002 00FF ABCD 5678 5678 FFFE 0000 0000 0 0000 0002 1
7 0 0 2 00 0 0 0 0 1 1 1234 0000 00FF ABCD 5678 5678 FFFE 0000 5676 8 0000 0000 0
1 0 4 0 00 0 0 0 0 1 1 1234 0000 0001 ABCD 5678 0001 FFFE 0000 5676 8 0000 0000 0
7 0 0 3 00 0 0 0 0 1 1 1234 0000 00FF ABCD FFFF 0001 FFFE 0000 0000 C 0000 0000 0
7 1 0 1 00 1 0 0 0 1 1 1234 0000 00FF ABCD 5678 0001 FFFE 0000 FFFF 2 0000 0000 0
7 1 0 3 00 1 0 0 0 1 1 1234 0000 00FF ABCD 0001 0001 FFFE 0000 0000 D 0000 0000 0
1 0 4 0 00 0 0 0 0 1 1 1234 0000 F0F0 ABCD 5678 F0F0 FFFE 0000 0000 D 0000 0000 0
7 2 0 0 00 0 0 0 0 1 1 1234 0000 00FF ABCD 5678 F0F0 FFFE 0000 7030 0 0000 0000 0
7 3 0 2 04 0 0 0 0 1 1 1234 0000 00FF ABCD 5678 F0F0 FFFE 0000 F0FE 2 0000 0000 0
7 4 0 3 00 0 0 0 0 1 1 1234 0000 00FF ABCD F0F0 F0F0 FFFE 0000 0000 5 0000 0000 0
7 5 0 3 02 0 0 0 0 1 1 1234 0000 00FF ABCD ABCD F0F0 FFFE 0000 AB0D 2 0000 0000 0
7 5 7 3 01 0 1 0 0 1 1 1234 0000 00FF ABCD ABCD F0F0 FFFE 0000 ABC0 2 ABC0 0000 0
7 0 0 3 00 1 0 0 0 1 1 1234 0000 00FF ABCD 1234 F0F0 FFFE 0000 0325 8 0000 0000 0
8 0 0 0 00 0 0 0 1 1 1 1234 0000 00FF ABCD 5678 F0F0 FFFE 0000 8192 8 0000 0000 0
8 0 0 0 00 0 0 0 0 1 1 1234 0000 00FF ABCD 5678 F0F0 FFFE 0000 40C9 8 0000 0000 0
8 0 0 0 00 0 0 0 1 1 1 1234 0000 00FF ABCD 5678 F0F0 FFFE 0000 A064 8 0000 0000 0
7 0 5 0 00 0 1 0 0 0 1 1234 0000 00FF ABCD 5678 F0F0 FFFE 0000 A064 8 A064 0000 0
0 0 0 0 00 0 0 2 0 1 0 1234 0000 00FF ABCD 5678 F0F0 FFFE 0000 A064 8 0000 0000 1
1 0 5 0 00 0 1 0 0 1 1 1234 0000 00FF ABCD 5678 A064 FFFE 0000 A064 8 A064 0000 0
